/* design/frontEnd_params.svh */
// shared widths and funct3 codes; RESET_PC must be word aligned, XLEN is fixed at 32 for RV32I
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

`define XLEN            32
`define INST_W          32
`define OPCODE_W        7
`define REG_ADDR_W      5
`define INST_ID_DEPTH   6

`define RESET_PC        32'h0000_0000   // first fetch after reset

// OP group, SUB and SRA use inst[30]
`define FUNCT3_ADD      3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_SLT      3'b010
`define FUNCT3_SLTU     3'b011
`define FUNCT3_XOR      3'b100
`define FUNCT3_SRL      3'b101
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111

// OP_IMM group
`define FUNCT3_ADDI     3'b000
`define FUNCT3_SLLI     3'b001
`define FUNCT3_SLTI     3'b010
`define FUNCT3_SLTIU    3'b011
`define FUNCT3_XORI     3'b100
`define FUNCT3_SRLI     3'b101   // SRAI when inst[30] set
`define FUNCT3_ORI      3'b110
`define FUNCT3_ANDI     3'b111

// branches
`define FUNCT3_BEQ      3'b000
`define FUNCT3_BNE      3'b001
`define FUNCT3_BLT      3'b100
`define FUNCT3_BGE      3'b101
`define FUNCT3_BLTU     3'b110
`define FUNCT3_BGEU     3'b111

`define FUNCT3_JALR     3'b000

// loads and stores
`define FUNCT3_LB       3'b000
`define FUNCT3_LH       3'b001
`define FUNCT3_LW       3'b010
`define FUNCT3_LBU      3'b100
`define FUNCT3_LHU      3'b101
`define FUNCT3_SB       3'b000
`define FUNCT3_SH       3'b001
`define FUNCT3_SW       3'b010

`endif

/* design/frontEndPkg.sv */
// front end types only; frontEnd_params.svh must be on the include path
`include "frontEnd_params.svh"

package frontEndPkg;

    // RV32I major opcodes handled by the decoder
    typedef enum logic [`OPCODE_W-1:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } rvOpcodeE;

    typedef enum logic [`INST_ID_DEPTH-1:0] {
        ID_NONE = '0,       // unknown or unsupported
        ID_ADD,
        ID_SUB,
        ID_AND,
        ID_OR,
        ID_XOR,
        ID_SLL,
        ID_SRL,
        ID_SRA,
        ID_SLT,
        ID_SLTU,
        ID_ADDI,
        ID_ANDI,
        ID_ORI,
        ID_XORI,
        ID_SLTI,
        ID_SLTIU,
        ID_SLLI,
        ID_SRLI,
        ID_SRAI,
        ID_LUI,
        ID_AUIPC,
        ID_BEQ,
        ID_BNE,
        ID_BLT,
        ID_BGE,
        ID_BLTU,
        ID_BGEU,
        ID_JAL,
        ID_JALR,
        ID_LW,
        ID_LH,
        ID_LB,
        ID_LHU,
        ID_LBU,
        ID_SW,
        ID_SB,
        ID_SH
    } instIdE;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        instIdE                 instId;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rs1Vld;
        logic                   rs2Vld;
        logic                   rdVld;
        logic [`XLEN-1:0]       imm;    // already sign extended
    } decodedInst;

    typedef struct packed {
        decodedInst       dec;
        logic [`XLEN-1:0] rs1Val;   // zero when source unused
        logic [`XLEN-1:0] rs2Val;
    } issuePacket;

    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } regWrite;

endpackage

/* design/fetchUnit.sv */
// PC register; JAL target is pc + decoded imm, no misaligned-target check, stall holds pc
`timescale 1ns/10ps
`include "frontEnd_params.svh"

module fetchUnit (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             jmpVld,
    input  logic [`XLEN-1:0] jmpOffset,
    output logic [`XLEN-1:0] pc
);

    logic [`XLEN-1:0] seqPc;
    logic [`XLEN-1:0] jmpTarget;
    logic [`XLEN-1:0] nextPc;

    assign seqPc     = pc + `XLEN'd4;
    assign jmpTarget = pc + jmpOffset;   // offset is relative to the jal itself

    // jal redirects fetch straight away, no bubble
    always_comb begin
        if (jmpVld) begin
            nextPc = jmpTarget;
        end else begin
            nextPc = seqPc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

endmodule

/* design/instDecode.sv */
// pure combinational RV32I decode; FENCE, CSR, ECALL and compressed forms decode as ID_NONE
`timescale 1ns/10ps
`include "frontEnd_params.svh"

module instDecode import frontEndPkg::*; (
    input  logic [`INST_W-1:0] inst,
    input  logic [`XLEN-1:0]   pc,
    output decodedInst         dec,
    output logic               jmpVld    // to fetch, same cycle
);

    rvOpcodeE         opcode;
    logic [2:0]       funct3;
    logic             altFn;     // inst[30], picks SUB/SRA/SRAI
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] immB;
    logic [`XLEN-1:0] immU;
    logic [`XLEN-1:0] immJ;

    assign opcode = rvOpcodeE'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign altFn  = inst[30];

    // every immediate format, selected below by opcode
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'd0};
    assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign jmpVld = (opcode == JAL);

    always_comb begin
        dec     = '0;
        dec.pc  = pc;
        dec.rs1 = inst[19:15];   // fixed positions in every format
        dec.rs2 = inst[24:20];
        dec.rd  = inst[11:7];

        case (opcode)
            OP_IMM: begin
                {dec.rs1Vld, dec.rs2Vld, dec.rdVld} = 3'b101;
                dec.imm = immI;
                case (funct3)
                    `FUNCT3_ADDI:  dec.instId = ID_ADDI;
                    `FUNCT3_SLTI:  dec.instId = ID_SLTI;
                    `FUNCT3_SLTIU: dec.instId = ID_SLTIU;
                    `FUNCT3_XORI:  dec.instId = ID_XORI;
                    `FUNCT3_ORI:   dec.instId = ID_ORI;
                    `FUNCT3_ANDI:  dec.instId = ID_ANDI;
                    `FUNCT3_SLLI:  dec.instId = ID_SLLI;
                    `FUNCT3_SRLI:  dec.instId = altFn ? ID_SRAI : ID_SRLI;
                    default:       dec.instId = ID_NONE;
                endcase
            end

            OP: begin
                {dec.rs1Vld, dec.rs2Vld, dec.rdVld} = 3'b111;
                case (funct3)
                    `FUNCT3_ADD:  dec.instId = altFn ? ID_SUB : ID_ADD;
                    `FUNCT3_SLL:  dec.instId = ID_SLL;
                    `FUNCT3_SLT:  dec.instId = ID_SLT;
                    `FUNCT3_SLTU: dec.instId = ID_SLTU;
                    `FUNCT3_XOR:  dec.instId = ID_XOR;
                    `FUNCT3_SRL:  dec.instId = altFn ? ID_SRA : ID_SRL;
                    `FUNCT3_OR:   dec.instId = ID_OR;
                    `FUNCT3_AND:  dec.instId = ID_AND;
                    default:      dec.instId = ID_NONE;
                endcase
            end

            LUI: begin
                {dec.rs1Vld, dec.rs2Vld, dec.rdVld} = 3'b001;
                dec.imm    = immU;
                dec.instId = ID_LUI;
            end

            AUIPC: begin
                {dec.rs1Vld, dec.rs2Vld, dec.rdVld} = 3'b001;
                dec.imm    = immU;
                dec.instId = ID_AUIPC;
            end

            BRANCH: begin
                // resolved later, only decoded here
                {dec.rs1Vld, dec.rs2Vld, dec.rdVld} = 3'b110;
                dec.imm = immB;
                case (funct3)
                    `FUNCT3_BEQ:  dec.instId = ID_BEQ;
                    `FUNCT3_BNE:  dec.instId = ID_BNE;
                    `FUNCT3_BLT:  dec.instId = ID_BLT;
                    `FUNCT3_BGE:  dec.instId = ID_BGE;
                    `FUNCT3_BLTU: dec.instId = ID_BLTU;
                    `FUNCT3_BGEU: dec.instId = ID_BGEU;
                    default:      dec.instId = ID_NONE;
                endcase
            end

            JAL: begin
                {dec.rs1Vld, dec.rs2Vld, dec.rdVld} = 3'b001;
                dec.imm    = immJ;
                dec.instId = ID_JAL;
            end

            JALR: begin
                {dec.rs1Vld, dec.rs2Vld, dec.rdVld} = 3'b101;
                dec.imm    = immI;
                dec.instId = (funct3 == `FUNCT3_JALR) ? ID_JALR : ID_NONE;
            end

            LOAD: begin
                {dec.rs1Vld, dec.rs2Vld, dec.rdVld} = 3'b101;
                dec.imm = immI;
                case (funct3)
                    `FUNCT3_LB:  dec.instId = ID_LB;
                    `FUNCT3_LH:  dec.instId = ID_LH;
                    `FUNCT3_LW:  dec.instId = ID_LW;
                    `FUNCT3_LBU: dec.instId = ID_LBU;
                    `FUNCT3_LHU: dec.instId = ID_LHU;
                    default:     dec.instId = ID_NONE;
                endcase
            end

            STORE: begin
                {dec.rs1Vld, dec.rs2Vld, dec.rdVld} = 3'b110;
                dec.imm = immS;
                case (funct3)
                    `FUNCT3_SB: dec.instId = ID_SB;
                    `FUNCT3_SH: dec.instId = ID_SH;
                    `FUNCT3_SW: dec.instId = ID_SW;
                    default:    dec.instId = ID_NONE;
                endcase
            end

            default: begin
                // unknown opcode, valid bits and imm stay clear
                dec.instId = ID_NONE;
            end
        endcase
    end

endmodule

/* design/operandFetch.sv */
// 31x32 register file, x0 reads zero; same-cycle writeback is bypassed to the reads
`timescale 1ns/10ps
`include "frontEnd_params.svh"

module operandFetch import frontEndPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  decodedInst dec,
    input  regWrite    wb,
    output logic       issueValid,
    output issuePacket issue
);

    logic [`XLEN-1:0] regFile [1:31];   // x0 is not stored
    logic [`XLEN-1:0] rs1Val;
    logic [`XLEN-1:0] rs2Val;
    issuePacket       nextIssue;

    // one read port, zero when unused or x0
    function automatic logic [`XLEN-1:0] readPort(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic                   vld
    );
        logic [`XLEN-1:0] val;
        if (!vld || addr == '0) begin
            val = '0;
        end else if (wb.en && wb.addr == addr) begin
            val = wb.data;   // bypass
        end else begin
            val = regFile[addr];
        end
        return val;
    endfunction

    // writeback ignores stall
    always_ff @(posedge clk) begin
        if (wb.en && wb.addr != '0) begin
            regFile[wb.addr] <= wb.data;
        end
    end

    always_comb begin
        rs1Val = readPort(dec.rs1, dec.rs1Vld);
        rs2Val = readPort(dec.rs2, dec.rs2Vld);
    end

    always_comb begin
        nextIssue.dec    = dec;
        nextIssue.rs1Val = rs1Val;
        nextIssue.rs2Val = rs2Val;
    end

    // issue stage register, held with fetch under stall
    always_ff @(posedge clk) begin
        if (rst) begin
            issueValid <= 1'b0;
            issue      <= '0;
        end else if (!stall) begin
            issueValid <= 1'b1;
            issue      <= nextIssue;
        end
    end

endmodule

/* design/rvFrontEnd.sv */
// fetch, decode and operand read; imem must answer combinationally, no execute or branch resolve
`timescale 1ns/10ps
`include "frontEnd_params.svh"

module rvFrontEnd import frontEndPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  logic [`INST_W-1:0] inst,      // imem data for fetchPc, same cycle
    input  regWrite            wb,
    output logic [`XLEN-1:0]   fetchPc,
    output logic               issueValid,
    output issuePacket         issue
);

    decodedInst dec;
    logic       jmpVld;

    fetchUnit uFetch (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .jmpVld    (jmpVld),
        .jmpOffset (dec.imm),   // J-type offset on a jal
        .pc        (fetchPc)
    );

    instDecode uDecode (
        .inst   (inst),
        .pc     (fetchPc),
        .dec    (dec),
        .jmpVld (jmpVld)
    );

    operandFetch uOperand (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .dec        (dec),
        .wb         (wb),
        .issueValid (issueValid),
        .issue      (issue)
    );

endmodule

/* tb/frontEnd_props.sv */
// protocol checks on the front end ports; assumes rst is high from time zero
`timescale 1ns/10ps
`include "frontEnd_params.svh"

module frontEndProps import frontEndPkg::*; (
    input logic             clk,
    input logic             rst,
    input logic             stall,
    input logic [`XLEN-1:0] fetchPc,
    input logic             issueValid,
    input issuePacket       issue
);

    // nothing issued right after reset
    assert property (@(posedge clk) rst |=> !issueValid)
        else $error("issueValid high in the cycle after reset");

    assert property (@(posedge clk) (stall && !rst) |=> ($stable(fetchPc) && $stable(issue)))
        else $error("fetchPc or issue moved while stalled");

    assert property (@(posedge clk) disable iff (rst)
        !issue.dec.rs1Vld |-> issue.rs1Val == '0)
        else $error("rs1Val nonzero for an unused source");

endmodule

bind rvFrontEnd frontEndProps uProps (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .fetchPc    (fetchPc),
    .issueValid (issueValid),
    .issue      (issue)
);

/* tb/frontEndTb.sv */
// directed front end tests; imem model covers 1 KiB from address 0, RESET_PC assumed inside it
`timescale 1ns/10ps
`include "frontEnd_params.svh"

module frontEndTb import frontEndPkg::*; ();

    localparam int FMT_R = 0;
    localparam int FMT_I = 1;
    localparam int FMT_S = 2;
    localparam int FMT_B = 3;
    localparam int FMT_U = 4;
    localparam int FMT_J = 5;
    localparam int WAIT_LIMIT = 20;   // cycles per wait loop

    logic               clk;
    logic               rst;
    logic               stall;
    logic [`INST_W-1:0] inst;
    regWrite            wb;
    logic [`XLEN-1:0]   fetchPc;
    logic               issueValid;
    issuePacket         issue;

    logic [31:0] imem [0:255];
    integer      seed;
    int          errors;
    int          checks;

    assign inst = imem[fetchPc[9:2]];   // same-cycle answer

    rvFrontEnd DUT (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .inst       (inst),
        .wb         (wb),
        .fetchPc    (fetchPc),
        .issueValid (issueValid),
        .issue      (issue)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic int fmtOf(input instIdE id);
        case (id)
            ID_ADD, ID_SUB, ID_AND, ID_OR, ID_XOR, ID_SLL, ID_SRL, ID_SRA, ID_SLT,
            ID_SLTU: return FMT_R;
            ID_SW, ID_SB, ID_SH: return FMT_S;
            ID_BEQ, ID_BNE, ID_BLT, ID_BGE, ID_BLTU, ID_BGEU: return FMT_B;
            ID_LUI, ID_AUIPC: return FMT_U;
            ID_JAL: return FMT_J;
            default: return FMT_I;
        endcase
    endfunction

    function automatic logic [6:0] opOf(input instIdE id);
        case (id)
            ID_LUI: return LUI;
            ID_AUIPC: return AUIPC;
            ID_JAL: return JAL;
            ID_JALR: return JALR;
            ID_LW, ID_LH, ID_LB, ID_LHU, ID_LBU: return LOAD;
            default: begin
                case (fmtOf(id))
                    FMT_R: return OP;
                    FMT_S: return STORE;
                    FMT_B: return BRANCH;
                    default: return OP_IMM;
                endcase
            end
        endcase
    endfunction

    // funct3 values are shared across groups, so items are grouped by value
    function automatic logic [2:0] f3Of(input instIdE id);
        case (id)
            ID_SLL, ID_SLLI, ID_BNE, ID_LH, ID_SH: return `FUNCT3_SLL;
            ID_SLT, ID_SLTI, ID_LW, ID_SW: return `FUNCT3_SLT;
            ID_SLTU, ID_SLTIU: return `FUNCT3_SLTU;
            ID_XOR, ID_XORI, ID_BLT, ID_LBU: return `FUNCT3_XOR;
            ID_SRL, ID_SRA, ID_SRLI, ID_SRAI, ID_BGE, ID_LHU: return `FUNCT3_SRL;
            ID_OR, ID_ORI, ID_BLTU: return `FUNCT3_OR;
            ID_AND, ID_ANDI, ID_BGEU: return `FUNCT3_AND;
            default: return `FUNCT3_ADD;
        endcase
    endfunction

    // immediate the decoder should report for a raw random value
    function automatic logic [31:0] normImm(input instIdE id, input logic [31:0] raw);
        case (fmtOf(id))
            FMT_R: return 32'd0;
            FMT_S: return {{20{raw[11]}}, raw[11:0]};
            FMT_B: return {{19{raw[12]}}, raw[12:1], 1'b0};
            FMT_U: return {raw[31:12], 12'd0};
            FMT_J: return {{11{raw[20]}}, raw[20:1], 1'b0};
            default: begin
                if (id == ID_SLLI || id == ID_SRLI) return {27'd0, raw[4:0]};
                if (id == ID_SRAI) return {20'd0, 7'h20, raw[4:0]};
                return {{20{raw[11]}}, raw[11:0]};
            end
        endcase
    endfunction

    function automatic logic [31:0] encode(input instIdE id, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [4:0] rd,
                                           input logic [31:0] imm);
        logic [6:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        op = opOf(id);
        f3 = f3Of(id);
        f7 = (id == ID_SUB || id == ID_SRA) ? 7'h20 : 7'h00;
        case (fmtOf(id))
            FMT_R: return {f7, rs2, rs1, f3, rd, op};
            FMT_S: return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
            FMT_B: return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
            FMT_U: return {imm[31:12], rd, op};
            FMT_J: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
            default: return {imm[11:0], rs1, f3, rd, op};
        endcase
    endfunction

    function automatic decodedInst expDec(input logic [31:0] w, input instIdE id,
                                          input logic [31:0] pc, input logic [31:0] imm);
        decodedInst d;
        d = '0;
        d.pc = pc;
        d.instId = id;
        d.rs1 = w[19:15];   // fields always taken from fixed bits
        d.rs2 = w[24:20];
        d.rd = w[11:7];
        d.imm = imm;
        case (fmtOf(id))
            FMT_R: {d.rs1Vld, d.rs2Vld, d.rdVld} = 3'b111;
            FMT_S, FMT_B: {d.rs1Vld, d.rs2Vld, d.rdVld} = 3'b110;
            FMT_U, FMT_J: {d.rs1Vld, d.rs2Vld, d.rdVld} = 3'b001;
            default: {d.rs1Vld, d.rs2Vld, d.rdVld} = 3'b101;
        endcase
        return d;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compareDec(input decodedInst got, input decodedInst exp);
        checkVal("issue.dec.pc", got.pc, exp.pc);
        checkVal("issue.dec.instId", 32'(got.instId), 32'(exp.instId));
        checkVal("issue.dec.rs1", 32'(got.rs1), 32'(exp.rs1));
        checkVal("issue.dec.rs2", 32'(got.rs2), 32'(exp.rs2));
        checkVal("issue.dec.rd", 32'(got.rd), 32'(exp.rd));
        checkVal("issue.dec.vld", 32'({got.rs1Vld, got.rs2Vld, got.rdVld}),
                 32'({exp.rs1Vld, exp.rs2Vld, exp.rdVld}));
        checkVal("issue.dec.imm", got.imm, exp.imm);
    endtask

    task automatic tick;
        @(posedge clk);
        #1;
    endtask

    task automatic waitIssue(input logic [31:0] pc);
        int cnt;
        cnt = 0;
        while (!(issueValid && issue.dec.pc == pc) && cnt < WAIT_LIMIT) begin
            tick;
            cnt++;
        end
        if (!(issueValid && issue.dec.pc == pc)) begin
            errors++;
            $display("timeout: instruction at pc %08h was never issued", pc);
        end
    endtask

    task automatic fillMem;
        for (int i = 0; i < 256; i++) begin
            imem[i] = encode(ID_ADDI, 5'd0, 5'd0, 5'd0, 32'(i));   // addi x0, x0, index
        end
    endtask

    task automatic doReset;
        rst = 1'b1;
        stall = 1'b0;
        wb = '0;
        tick;
        tick;
        rst = 1'b0;
    endtask

    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        wb.en = 1'b1;
        wb.addr = addr;
        wb.data = data;
        tick;
        wb = '0;
    endtask

    task automatic resetBehavior;
        fillMem;
        doReset;
        checkVal("issueValid", 32'(issueValid), 32'd0);
        checkVal("fetchPc", fetchPc, `RESET_PC);
        tick;
        checkVal("issueValid", 32'(issueValid), 32'd1);
    endtask

    task automatic decodeEachFormat;
        decodedInst expQ [$];
        instIdE     id;
        logic [31:0] imm;
        logic [31:0] w;
        logic [31:0] pc;
        int          n;
        n = 0;
        fillMem;
        for (int i = 1; i <= 37; i++) begin
            id = instIdE'(i[5:0]);
            if (id != ID_JAL) begin   // jal gets its own test
                imm = normImm(id, $random(seed));
                w = encode(id, 5'($random(seed)), 5'($random(seed)), 5'($random(seed)), imm);
                imem[n] = w;
                expQ.push_back(expDec(w, id, `RESET_PC + 32'(4 * n), imm));
                n++;
            end
        end
        doReset;
        for (int k = 0; k < n; k++) begin
            pc = `RESET_PC + 32'(4 * k);
            waitIssue(pc);
            compareDec(issue.dec, expQ[k]);
            checkVal("fetchPc", fetchPc, pc + 32'd4);
            tick;
        end
    endtask

    task automatic jalRedirect;
        logic [31:0] off;
        logic [31:0] target;
        fillMem;
        off = 32'(4 * (64 + ($random(seed) & 31)));
        target = 32'd4 + off;
        imem[1] = encode(ID_JAL, 5'd0, 5'd0, 5'd1, off);
        imem[target[9:2]] = encode(ID_ADDI, 5'd0, 5'd0, 5'd7, 32'h5a5);   // marker
        doReset;
        waitIssue(32'd4);
        checkVal("issue.dec.instId", 32'(issue.dec.instId), 32'(ID_JAL));
        checkVal("issue.dec.imm", issue.dec.imm, off);
        checkVal("fetchPc", fetchPc, target);
        tick;
        checkVal("issue.dec.pc", issue.dec.pc, target);
        checkVal("issue.dec.imm", issue.dec.imm, 32'h5a5);
    endtask

    task automatic regFileAccess;
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] vc;
        va = $random(seed);
        vb = $random(seed);
        vc = $random(seed);
        fillMem;
        imem[0] = encode(ID_ADD, 5'd5, 5'd9, 5'd3, 32'd0);
        imem[1] = encode(ID_ADD, 5'd12, 5'd0, 5'd3, 32'd0);
        imem[2] = encode(ID_ADD, 5'd0, 5'd12, 5'd3, 32'd0);
        doReset;
        stall = 1'b1;   // hold pc at the first add while writing
        writeReg(5'd5, va);
        writeReg(5'd9, vb);
        writeReg(5'd0, 32'hdead_beef);
        stall = 1'b0;
        waitIssue(32'd0);
        checkVal("issue.rs1Val", issue.rs1Val, va);
        checkVal("issue.rs2Val", issue.rs2Val, vb);
        // x12 written in the same cycle that the second add reads it
        wb.en = 1'b1;
        wb.addr = 5'd12;
        wb.data = vc;
        tick;
        wb = '0;
        waitIssue(32'd4);
        checkVal("issue.rs1Val", issue.rs1Val, vc);
        checkVal("issue.rs2Val", issue.rs2Val, 32'd0);
        // x0 written in the same cycle that the third add reads it
        wb.en = 1'b1;
        wb.addr = 5'd0;
        wb.data = 32'hdead_beef;
        tick;
        wb = '0;
        waitIssue(32'd8);
        checkVal("issue.rs1Val", issue.rs1Val, 32'd0);
        checkVal("issue.rs2Val", issue.rs2Val, vc);
    endtask

    task automatic stallHold;
        logic [31:0] p;
        issuePacket  held;
        fillMem;
        doReset;
        tick;
        tick;
        p = fetchPc;
        held = issue;
        stall = 1'b1;
        for (int i = 0; i < 5; i++) begin
            tick;
            checkVal("fetchPc", fetchPc, p);
            checkVal("issue.dec.pc", issue.dec.pc, held.dec.pc);
            checkVal("issue.dec.imm", issue.dec.imm, held.dec.imm);
        end
        stall = 1'b0;
        tick;
        checkVal("issue.dec.pc", issue.dec.pc, p);
        checkVal("issue.dec.imm", issue.dec.imm, 32'(p[9:2]));
        checkVal("fetchPc", fetchPc, p + 32'd4);
        tick;
        checkVal("issue.dec.pc", issue.dec.pc, p + 32'd4);
    endtask

    task automatic unknownAndUnused;
        logic [31:0] luiImm;
        fillMem;
        luiImm = normImm(ID_LUI, $random(seed) | 32'h0108_8000);   // nonzero rs1/rs2 bits
        imem[0] = {25'($random(seed)), 7'b1111111};
        imem[1] = encode(ID_LUI, 5'd0, 5'd0, 5'd4, luiImm);
        doReset;
        stall = 1'b1;
        for (int r = 1; r < 32; r++) begin
            writeReg(5'(r), $random(seed) | 32'h1);
        end
        stall = 1'b0;
        waitIssue(32'd0);
        checkVal("issue.dec.instId", 32'(issue.dec.instId), 32'(ID_NONE));
        checkVal("issue.dec.vld", 32'({issue.dec.rs1Vld, issue.dec.rs2Vld, issue.dec.rdVld}), 0);
        checkVal("issue.dec.imm", issue.dec.imm, 32'd0);
        checkVal("issue.rs1Val", issue.rs1Val, 32'd0);
        checkVal("issue.rs2Val", issue.rs2Val, 32'd0);
        waitIssue(32'd4);
        checkVal("issue.dec.instId", 32'(issue.dec.instId), 32'(ID_LUI));
        checkVal("issue.dec.imm", issue.dec.imm, luiImm);
        checkVal("issue.rs1Val", issue.rs1Val, 32'd0);
        checkVal("issue.rs2Val", issue.rs2Val, 32'd0);
    endtask

    initial begin
        seed = 32'h67cb;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        stall = 1'b0;
        wb = '0;
        resetBehavior;
        decodeEachFormat;
        jalRedirect;
        regFileAccess;
        stallHold;
        unknownAndUnused;
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // whole-run limit in case a task never returns
    initial begin
        #1ms;
        $display("simulation ran past its time limit");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* all.f */
+incdir+design
design/frontEndPkg.sv
design/fetchUnit.sv
design/instDecode.sv
design/operandFetch.sv
design/rvFrontEnd.sv
tb/frontEnd_props.sv
tb/frontEndTb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f all.f --top-module frontEndTb -o simFrontEnd \
    && ./obj_dir/simFrontEnd | tee /dev/stderr | grep -q "TEST PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
